//--- pr_shell_pkg.sv
package pr_shell_pkg;

    // Shell dimensions
    localparam int N_REGIONS   = 4;
    localparam int DATA_BITS   = 32;
    localparam int ID_BITS     = 6;  // Process id carried in tid
    localparam int KEEP_BITS   = DATA_BITS / 8;
    localparam int REGION_BITS = $clog2(N_REGIONS);

    // Region number
    typedef logic [REGION_BITS-1:0] region_t;

    // Beat payload fields
    typedef logic [DATA_BITS-1:0] data_t;
    typedef logic [KEEP_BITS-1:0] keep_t;  // Byte enables
    typedef logic [ID_BITS-1:0]   id_t;

    // One bit per region, for decouple request and status
    typedef logic [N_REGIONS-1:0] region_mask_t;

    // One stream beat without its handshake
    typedef struct packed {
        data_t data;
        keep_t keep;
        id_t   id;
        logic  last;
    } axis_beat_t;

    // Host ingress beat, tagged with its destination region
    typedef struct packed {
        region_t    region;
        axis_beat_t beat;
    } host_beat_t;

endpackage

//--- region_dispatch.sv
`timescale 1ns/1ps

module region_dispatch (
    input  logic                       aclk,
    input  logic                       rst_n,

    input  logic                       s_valid,
    output logic                       s_ready,
    input  pr_shell_pkg::host_beat_t   s_beat,

    output pr_shell_pkg::region_mask_t r_valid,
    input  pr_shell_pkg::region_mask_t r_ready,
    output pr_shell_pkg::axis_beat_t   r_beat
);
    import pr_shell_pkg::*;

    region_t lock_region;  // Region of the packet in flight
    logic    pkt_open;
    region_t sel;
    logic    xfer;

    // First beat picks the region and later beats follow the lock
    assign sel  = pkt_open ? lock_region : s_beat.region;
    assign xfer = s_valid && s_ready;

    always_comb begin
        r_valid      = '0;
        r_valid[sel] = s_valid;
    end

    assign s_ready = r_ready[sel];
    assign r_beat  = s_beat.beat;  // Shared by all regions while valid does the steering

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            pkt_open    <= 1'b0;
            lock_region <= '0;
        end else if (xfer) begin
            pkt_open    <= !s_beat.beat.last;  // Released after tlast
            lock_region <= sel;
        end
    end

    // Only one region may see the host stream at a time
    assert property (@(posedge aclk) disable iff (!rst_n)
        $onehot0(r_valid))
    else $error("region_dispatch: more than one r_valid high");

endmodule

//--- axis_skid_slice.sv
`timescale 1ns/1ps

module axis_skid_slice (
    input  logic                     aclk,
    input  logic                     rst_n,

    input  logic                     s_valid,
    output logic                     s_ready,
    input  pr_shell_pkg::axis_beat_t s_beat,

    output logic                     m_valid,
    input  logic                     m_ready,
    output pr_shell_pkg::axis_beat_t m_beat
);
    import pr_shell_pkg::*;

    logic       main_valid;
    logic       skid_valid;
    axis_beat_t skid_beat;
    logic       push;
    logic       pop;
    logic       load_main;
    logic       load_skid;

    assign m_valid = main_valid;
    assign s_ready = !skid_valid;  // Fill level only
    assign push    = s_valid && s_ready;
    assign pop     = main_valid && m_ready;

    // New beat goes to main when main is free or draining, else to skid
    assign load_main = push && (!main_valid || pop);
    assign load_skid = push && main_valid && !pop;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
        end else if (skid_valid) begin
            if (pop)
                skid_valid <= 1'b0;  // Skid moves up into main
        end else begin
            if (!main_valid || pop)
                main_valid <= push;
            if (load_skid)
                skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (skid_valid && pop)
            m_beat <= skid_beat;
        else if (load_main)
            m_beat <= s_beat;
        if (load_skid)
            skid_beat <= s_beat;
    end

    // Stalled output holds its beat
    assert property (@(posedge aclk) disable iff (!rst_n)
        m_valid && !m_ready |=> m_valid && $stable(m_beat))
    else $error("axis_skid_slice: m_beat changed while stalled");

    assert property (@(posedge aclk) disable iff (!rst_n)
        push |-> !(main_valid && skid_valid))
    else $error("axis_skid_slice: beat accepted with both entries full");

endmodule

//--- decouple_ctrl.sv
`timescale 1ns/1ps

module decouple_ctrl (
    input  logic                       aclk,
    input  logic                       rst_n,

    input  pr_shell_pkg::region_mask_t decouple_req,  // Raw request per region

    // Egress handshake seen after the decoupler
    input  pr_shell_pkg::region_mask_t eg_valid,
    input  pr_shell_pkg::region_mask_t eg_ready,
    input  pr_shell_pkg::region_mask_t eg_last,

    output pr_shell_pkg::region_mask_t decouple
);
    import pr_shell_pkg::*;

    region_mask_t xfer;
    region_mask_t pkt_open;  // Packet started but tlast not yet seen
    region_mask_t boundary;

    assign xfer = eg_valid & eg_ready;

    // Idle with nothing moving, or the closing beat moves now
    assign boundary = (~pkt_open & ~xfer) | (xfer & eg_last);

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            pkt_open <= '0;
            decouple <= '0;
        end else begin
            pkt_open <= (pkt_open & ~xfer) | (xfer & ~eg_last);

            // Set only at a boundary, hold while requested, drop with the request
            decouple <= decouple_req & (decouple | boundary);
        end
    end

    for (genvar i = 0; i < N_REGIONS; i++) begin : g_chk
        // An open packet that does not end blocks decoupling
        assert property (@(posedge aclk) disable iff (!rst_n)
            pkt_open[i] && !(xfer[i] && eg_last[i]) |=> !$rose(decouple[i]))
        else $error("decouple_ctrl: region %0d decoupled mid-packet", i);
    end

endmodule

//--- axisr_decoupler.sv
`timescale 1ns/1ps

module axisr_decoupler (
    input  logic                       aclk,
    input  logic                       rst_n,
    input  pr_shell_pkg::region_mask_t decouple,

    input  pr_shell_pkg::region_mask_t s_valid,
    output pr_shell_pkg::region_mask_t s_ready,
    input  pr_shell_pkg::axis_beat_t   s_beat [pr_shell_pkg::N_REGIONS],

    output pr_shell_pkg::region_mask_t m_valid,
    input  pr_shell_pkg::region_mask_t m_ready,
    output pr_shell_pkg::axis_beat_t   m_beat [pr_shell_pkg::N_REGIONS]
);
    import pr_shell_pkg::*;

    // Handshake cut in both directions while a region is reconfigured
    assign m_valid = s_valid & ~decouple;
    assign s_ready = m_ready & ~decouple;

    for (genvar i = 0; i < N_REGIONS; i++) begin : g_region
        assign m_beat[i] = s_beat[i];  // Payload is never touched

        assert property (@(posedge aclk) disable iff (!rst_n)
            decouple[i] |-> !m_valid[i])
        else $error("axisr_decoupler: m_valid high on decoupled region %0d", i);
    end

endmodule

//--- pr_shell_top.sv
`timescale 1ns/1ps

module pr_shell_top (
    input  logic                       aclk,
    input  logic                       rst_n,

    // Host ingress
    input  logic                       s_valid,
    output logic                       s_ready,
    input  pr_shell_pkg::host_beat_t   s_beat,

    // Region egress
    output pr_shell_pkg::region_mask_t m_valid,
    input  pr_shell_pkg::region_mask_t m_ready,
    output pr_shell_pkg::axis_beat_t   m_beat [pr_shell_pkg::N_REGIONS],

    input  pr_shell_pkg::region_mask_t decouple_req,
    output pr_shell_pkg::region_mask_t decoupled
);
    import pr_shell_pkg::*;

    region_mask_t r_valid;
    region_mask_t r_ready;
    axis_beat_t   r_beat;   // Shared dispatch output
    region_mask_t sl_valid;
    region_mask_t sl_ready;
    axis_beat_t   sl_beat [N_REGIONS];
    region_mask_t eg_last;
    region_mask_t decouple;

    region_dispatch u_dispatch (
        .aclk, .rst_n,
        .s_valid, .s_ready, .s_beat,
        .r_valid, .r_ready, .r_beat
    );

    for (genvar i = 0; i < N_REGIONS; i++) begin : g_region
        axis_skid_slice u_slice (
            .aclk, .rst_n,
            .s_valid(r_valid[i]),  .s_ready(r_ready[i]),  .s_beat(r_beat),
            .m_valid(sl_valid[i]), .m_ready(sl_ready[i]), .m_beat(sl_beat[i])
        );

        assign eg_last[i] = m_beat[i].last;
    end

    decouple_ctrl u_ctrl (
        .aclk, .rst_n, .decouple_req,
        .eg_valid(m_valid), .eg_ready(m_ready), .eg_last,
        .decouple
    );

    axisr_decoupler u_decoupler (
        .aclk, .rst_n, .decouple,
        .s_valid(sl_valid), .s_ready(sl_ready), .s_beat(sl_beat),
        .m_valid, .m_ready, .m_beat
    );

    assign decoupled = decouple;  // Status mirrors the live gate

endmodule

//--- pr_shell_tb.sv
`timescale 1ns/1ps

module pr_shell_tb;
    import pr_shell_pkg::*;

    localparam int N_PACKETS   = 200;
    localparam int READY_LIMIT = 2000;  // Cycles one ingress beat may wait
    localparam int DRAIN_LIMIT = 4000;

    logic         aclk = 1'b0;
    logic         rst_n;
    logic         s_valid;
    logic         s_ready;
    host_beat_t   s_beat;
    region_mask_t m_valid;
    region_mask_t m_ready;
    axis_beat_t   m_beat [N_REGIONS];
    region_mask_t decouple_req;
    region_mask_t decoupled;

    int           seed = 32'h72b0;
    bit           stim_on = 1'b1;
    axis_beat_t   exp_q [N_REGIONS][$];  // Expected beats per region, oldest first
    region_mask_t eg_open;               // Egress packet started, tlast not seen yet
    region_mask_t stalled;
    axis_beat_t   stall_beat [N_REGIONS];

    pr_shell_top DUT (
        .aclk, .rst_n, .s_valid, .s_ready, .s_beat,
        .m_valid, .m_ready, .m_beat, .decouple_req, .decoupled
    );

    always #20 aclk = ~aclk;

    task automatic halt_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic bit all_queues_empty();
        for (int r = 0; r < N_REGIONS; r++) begin
            if (exp_q[r].size() != 0)
                return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic send_beat(host_beat_t hb, region_t dest);
        int waited;
        waited = 0;
        s_valid <= 1'b1;
        s_beat  <= hb;
        @(posedge aclk);
        while (!s_ready && waited < READY_LIMIT) begin
            waited++;
            @(posedge aclk);
        end
        if (!s_ready) begin
            $display("Timeout: ingress beat for region %0d was never accepted", dest);
            halt_run();
        end
        exp_q[dest].push_back(hb.beat);
    endtask

    task automatic send_packet();
        region_t    dest;
        int         len;
        host_beat_t hb;
        dest = region_t'(rand_below(N_REGIONS));
        len  = 1 + rand_below(6);
        for (int j = 0; j < len; j++) begin
            // Region field of later beats is noise the shell must ignore
            hb.region    = (j == 0) ? dest : region_t'(rand_below(N_REGIONS));
            hb.beat.data = data_t'($random(seed));
            hb.beat.keep = keep_t'($random(seed));
            hb.beat.id   = id_t'($random(seed));
            hb.beat.last = (j == len - 1);
            send_beat(hb, dest);
            if (rand_below(3) == 0) begin
                s_valid <= 1'b0;  // Idle gap
                repeat (1 + rand_below(3)) @(posedge aclk);
            end
        end
    endtask

    initial begin
        m_ready <= '0;
        forever begin
            @(posedge aclk);
            m_ready <= region_mask_t'($random(seed) | $random(seed));  // Mostly ready
        end
    end

    initial begin
        decouple_req <= '0;
        forever begin
            @(posedge aclk);
            for (int r = 0; r < N_REGIONS; r++) begin
                if (!rst_n || !stim_on)
                    decouple_req[r] <= 1'b0;
                else if (rand_below(24) == 0)
                    decouple_req[r] <= !decouple_req[r];  // Lands mid-packet as often as not
            end
        end
    end

    // Egress scoreboard and stall tracking
    always @(posedge aclk) begin
        axis_beat_t expected;
        if (!rst_n) begin
            eg_open <= '0;
            stalled  = '0;
        end else begin
            for (int r = 0; r < N_REGIONS; r++) begin
                if (stalled[r] && m_valid[r]) begin
                    assert (m_beat[r] == stall_beat[r]) else begin
                        $display("Fail at time %0t: m_beat[%0d] expected %h, got %h",
                                 $time, r, stall_beat[r], m_beat[r]);
                        halt_run();
                    end
                end
                stalled[r]    = m_valid[r] && !m_ready[r];
                stall_beat[r] = m_beat[r];
                if (m_valid[r] && m_ready[r]) begin
                    assert (exp_q[r].size() > 0) else begin
                        $display("Region %0d delivered a beat that was never sent", r);
                        halt_run();
                    end
                    expected = exp_q[r].pop_front();
                    assert (m_beat[r] == expected) else begin
                        $display("Fail at time %0t: m_beat[%0d] expected %h, got %h",
                                 $time, r, expected, m_beat[r]);
                        halt_run();
                    end
                    eg_open[r] <= !m_beat[r].last;
                end
            end
        end
    end

    for (genvar i = 0; i < N_REGIONS; i++) begin : g_check
        assert property (@(posedge aclk) disable iff (!rst_n)
            decoupled[i] |-> !m_valid[i])
        else begin
            $display("Fail at time %0t: m_valid[%0d] expected 0, got 1", $time, i);
            halt_run();
        end

        // Idle region goes quiet on the next edge
        assert property (@(posedge aclk) disable iff (!rst_n)
            decouple_req[i] && !eg_open[i] && !(m_valid[i] && m_ready[i]) |=> decoupled[i])
        else begin
            $display("Fail at time %0t: decoupled[%0d] expected 1, got 0", $time, i);
            halt_run();
        end

        assert property (@(posedge aclk) disable iff (!rst_n)
            decouple_req[i] && m_valid[i] && m_ready[i] && m_beat[i].last |=> decoupled[i])
        else begin
            $display("Fail at time %0t: decoupled[%0d] expected 1, got 0", $time, i);
            halt_run();
        end

        // Open packet that does not close now
        assert property (@(posedge aclk) disable iff (!rst_n)
            eg_open[i] && !(m_valid[i] && m_ready[i] && m_beat[i].last)
            |=> !$rose(decoupled[i]))
        else begin
            $display("Fail at time %0t: decoupled[%0d] expected 0, got 1", $time, i);
            halt_run();
        end

        assert property (@(posedge aclk) disable iff (!rst_n)
            !decouple_req[i] |=> !decoupled[i])
        else begin
            $display("Fail at time %0t: decoupled[%0d] expected 0, got 1", $time, i);
            halt_run();
        end
    end

    initial begin
        int waited;
        rst_n   <= 1'b0;
        s_valid <= 1'b0;
        s_beat  <= '0;
        repeat (5) @(posedge aclk);
        rst_n <= 1'b1;
        @(posedge aclk);
        assert (m_valid == '0) else begin
            $display("Fail at time %0t: m_valid expected %b, got %b",
                     $time, region_mask_t'(0), m_valid);
            halt_run();
        end
        assert (decoupled == '0) else begin
            $display("Fail at time %0t: decoupled expected %b, got %b",
                     $time, region_mask_t'(0), decoupled);
            halt_run();
        end
        assert (s_ready == 1'b1) else begin
            $display("Fail at time %0t: s_ready expected 1, got %b", $time, s_ready);
            halt_run();
        end

        for (int p = 0; p < N_PACKETS; p++)
            send_packet();
        s_valid <= 1'b0;
        stim_on  = 1'b0;  // Releases every region for the drain

        waited = 0;
        while (!all_queues_empty() && waited < DRAIN_LIMIT) begin
            waited++;
            @(posedge aclk);
        end
        if (all_queues_empty()) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Timeout: region queues did not drain in %0d cycles", DRAIN_LIMIT);
            halt_run();
        end
    end

endmodule

//--- pr_shell.f
pr_shell_pkg.sv
region_dispatch.sv
axis_skid_slice.sv
decouple_ctrl.sv
axisr_decoupler.sv
pr_shell_top.sv
pr_shell_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := pr_shell_tb
FILELIST := pr_shell.f
OBJ_DIR  := obj_dir
PASS_MSG := All tests passed!

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
